/* common/riscv_pkg.sv */
// RV32I memory and write-back definitions

package riscv_pkg;

    // data path and register index widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // memory operation carried down from execute
    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LBU = 4'd2,
        MEM_LH  = 4'd3,
        MEM_LHU = 4'd4,
        MEM_LW  = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_oper_t;

    // EX/MEM pipeline bundle
    typedef struct packed {
        // memory address for loads and stores, plain result otherwise
        logic [XLEN-1:0]       alu_result;
        // store data
        logic [XLEN-1:0]       oper2;
        mem_oper_t             mem_oper;
        logic                  trap;
        logic                  wb_use_mem;
        logic                  write_rd;
        logic [REG_ADDR_W-1:0] rd_addr;
    } ex_mem_t;

    // MEM/WB pipeline bundle
    typedef struct packed {
        logic                  wb_use_mem;
        logic                  write_rd;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       alu_result;
        // load data, already aligned and extended
        logic [XLEN-1:0]       dmem_rdata;
        logic                  trap;
    } mem_wb_t;

    // write-back port, also used for forwarding
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage : riscv_pkg

/* mem_stage/data_mem.sv */
// Byte-enabled data memory

`timescale 1ns/1ps

module data_mem
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic                       clk_i,

    // read port
    input  logic [riscv_pkg::XLEN-1:0] addr_i,
    input  logic                       read_i,
    output logic [riscv_pkg::XLEN-1:0] rdata_o,

    // write port
    input  logic [3:0]                 wsel_byte_i,
    input  logic [riscv_pkg::XLEN-1:0] wdata_i
);

    import riscv_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    // word storage, contents undefined until written
    logic [XLEN-1:0] mem [DMEM_WORDS];

    logic [IDX_W-1:0] word_idx;

    // upper address bits drop out, so accesses wrap
    assign word_idx = addr_i[2 +: IDX_W];

    // per-lane write at the end of the store cycle
    always_ff @(posedge clk_i)
    begin
        for (int lane = 0; lane < 4; lane++)
        begin
            if (wsel_byte_i[lane])
            begin
                mem[word_idx][8*lane +: 8] <= wdata_i[8*lane +: 8];
            end
        end
    end

    // combinational read
    always_comb
    begin
        if (read_i)
        begin
            rdata_o = mem[word_idx];
        end
        else
        begin
            rdata_o = '0;
        end
    end

endmodule : data_mem

/* mem_stage/mem_rw.sv */
// Load/store unit with MEM/WB registers

`timescale 1ns/1ps

module mem_rw
(
    input  logic                       clk_i,
    input  logic                       rstn_i,

    // from EX/MEM
    input  riscv_pkg::ex_mem_t         ex_mem_i,

    // data memory read port
    output logic [riscv_pkg::XLEN-1:0] rw_addr_o,
    output logic                       read_o,
    input  logic [riscv_pkg::XLEN-1:0] rdata_i,

    // data memory write port
    output logic [3:0]                 wsel_byte_o,
    output logic [riscv_pkg::XLEN-1:0] wdata_o,

    // MEM/WB registers
    output riscv_pkg::mem_wb_t         mem_wb_o
);

    import riscv_pkg::*;

    logic [XLEN-1:0] addr;
    logic [7:0]      byte_lane;
    logic [15:0]     half_lane;
    logic [XLEN-1:0] load_data;
    mem_wb_t         mem_wb_d;

    // low bits only pick the lane, misalignment is not flagged
    assign addr = ex_mem_i.alu_result;

    // lane pick from the fetched word
    assign byte_lane = rdata_i[8*addr[1:0] +: 8];
    assign half_lane = rdata_i[16*addr[1] +: 16];

    always_comb
    begin
        load_data   = '0;
        wsel_byte_o = '0;
        wdata_o     = '0;
        read_o      = 1'b0;

        case (ex_mem_i.mem_oper)
            MEM_LB:
            begin
                read_o    = 1'b1;
                load_data = XLEN'(signed'(byte_lane));
            end
            MEM_LBU:
            begin
                read_o    = 1'b1;
                load_data = XLEN'(byte_lane);
            end
            MEM_LH:
            begin
                read_o    = 1'b1;
                load_data = XLEN'(signed'(half_lane));
            end
            MEM_LHU:
            begin
                read_o    = 1'b1;
                load_data = XLEN'(half_lane);
            end
            MEM_LW:
            begin
                read_o    = 1'b1;
                load_data = rdata_i;
            end

            // stores shift data and mask into the addressed lanes
            MEM_SB:
            begin
                wsel_byte_o = 4'b0001 << addr[1:0];
                wdata_o     = ex_mem_i.oper2 << (8 * addr[1:0]);
            end
            MEM_SH:
            begin
                wsel_byte_o = 4'b0011 << (2 * addr[1]);
                wdata_o     = ex_mem_i.oper2 << (16 * addr[1]);
            end
            MEM_SW:
            begin
                wsel_byte_o = 4'b1111;
                wdata_o     = ex_mem_i.oper2;
            end

            default:
            begin
            end
        endcase
    end

    // address is held at zero when idle
    assign rw_addr_o = (ex_mem_i.mem_oper != MEM_NOP) ? addr : '0;

    // next MEM/WB contents
    always_comb
    begin
        mem_wb_d            = '0;
        mem_wb_d.wb_use_mem = ex_mem_i.wb_use_mem;
        mem_wb_d.write_rd   = ex_mem_i.write_rd;
        mem_wb_d.rd_addr    = ex_mem_i.rd_addr;
        mem_wb_d.alu_result = ex_mem_i.alu_result;
        mem_wb_d.dmem_rdata = load_data;
        mem_wb_d.trap       = ex_mem_i.trap;
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            mem_wb_o <= '0;
        end
        else
        begin
            mem_wb_o <= mem_wb_d;
        end
    end

    // a cycle is either a load or a store, never both
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(read_o && (wsel_byte_o != 4'b0000)))
    else $error("mem_rw: read and write strobes active together");

    // idle cycles must leave memory untouched
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (ex_mem_i.mem_oper == MEM_NOP) |-> (wsel_byte_o == 4'b0000))
    else $error("mem_rw: byte strobes on an idle cycle");

endmodule : mem_rw

/* rtl/reg_file.sv */
// Register file and write-back select

`timescale 1ns/1ps

module reg_file
(
    input  logic                             clk_i,
    input  logic                             rstn_i,

    // from MEM/WB
    input  riscv_pkg::mem_wb_t               mem_wb_i,

    // read ports for decode
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [riscv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [riscv_pkg::XLEN-1:0]       rs2_data_o,

    // write-back port that also leaves the top for forwarding
    output riscv_pkg::wb_t                   wb_o
);

    import riscv_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [NUM_REGS];

    logic [XLEN-1:0] wb_data;
    logic            wb_we;

    // result source is load data or the ALU value
    assign wb_data = mem_wb_i.wb_use_mem ? mem_wb_i.dmem_rdata : mem_wb_i.alu_result;

    // trapped items and x0 never write
    assign wb_we = mem_wb_i.write_rd
                 && !mem_wb_i.trap
                 && (mem_wb_i.rd_addr != '0);

    always_comb
    begin
        wb_o      = '0;
        wb_o.we   = wb_we;
        wb_o.addr = mem_wb_i.rd_addr;
        wb_o.data = wb_data;
    end

    // register array write
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb_o.we)
        begin
            regs[wb_o.addr] <= wb_o.data;
        end
    end

    // combinational reads without write bypass
    always_comb
    begin
        if (rs1_addr_i == '0)
        begin
            rs1_data_o = '0;
        end
        else
        begin
            rs1_data_o = regs[rs1_addr_i];
        end
    end

    always_comb
    begin
        if (rs2_addr_i == '0)
        begin
            rs2_data_o = '0;
        end
        else
        begin
            rs2_data_o = regs[rs2_addr_i];
        end
    end

    // write enable must stay low for trapped items
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_wb_i.trap |-> !wb_o.we)
    else $error("reg_file: write enabled while trap is set");

endmodule : reg_file

/* rtl/mem_wb_top.sv */
// Memory and write-back stage top level

`timescale 1ns/1ps

module mem_wb_top
#(
    parameter int DMEM_WORDS = 256
)
(
    input  logic                             clk_i,
    input  logic                             rstn_i,

    // from EX/MEM
    input  riscv_pkg::ex_mem_t               ex_mem_i,

    // decode read ports
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [riscv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [riscv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [riscv_pkg::XLEN-1:0]       rs2_data_o,

    // write-back and trap status
    output riscv_pkg::wb_t                   wb_o,
    output logic                             trap_o
);

    import riscv_pkg::*;

    // data memory bus
    logic [XLEN-1:0] dmem_addr;
    logic            dmem_read;
    logic [XLEN-1:0] dmem_rdata;
    logic [3:0]      dmem_wsel_byte;
    logic [XLEN-1:0] dmem_wdata;

    mem_wb_t         mem_wb;

    mem_rw u_mem_rw (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .ex_mem_i    (ex_mem_i),
        .rw_addr_o   (dmem_addr),
        .read_o      (dmem_read),
        .rdata_i     (dmem_rdata),
        .wsel_byte_o (dmem_wsel_byte),
        .wdata_o     (dmem_wdata),
        .mem_wb_o    (mem_wb)
    );

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem (
        .clk_i       (clk_i),
        .addr_i      (dmem_addr),
        .read_i      (dmem_read),
        .rdata_o     (dmem_rdata),
        .wsel_byte_i (dmem_wsel_byte),
        .wdata_i     (dmem_wdata)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .mem_wb_i   (mem_wb),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o),
        .wb_o       (wb_o)
    );

    assign trap_o = mem_wb.trap;

endmodule : mem_wb_top

/* tb/tb_clock_gen.sv */
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 3
)
(
    output logic clk_o,
    output logic rstn_o
);

    // free-running clock, 20 ns period
    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #HALF_PERIOD;
            clk_o = ~clk_o;
        end
    end

    // reset low for the first cycles, released on a falling edge
    initial
    begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule : tb_clock_gen

/* tb/tb_mem_wb.sv */
// Memory and write-back testbench

`timescale 1ns/1ps

module tb_mem_wb;

    import riscv_pkg::*;

    localparam int DMEM_WORDS = 256;
    localparam int BYTE_W     = $clog2(DMEM_WORDS) + 2;
    localparam int N_RANDOM   = 200;
    localparam int REG_SCAN   = 17;
    // item count over six register scans, eight drains and the test bodies
    localparam int NUM_OPS    = 6 * REG_SCAN + 8 * 2 + 4 + 4 * 14 + 4 * 13 + 4 + 16 + N_RANDOM;
    localparam int MAX_CYCLES = NUM_OPS * 3 + 20;

    logic                  clk;
    logic                  rstn;
    ex_mem_t               ex_mem;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    wb_t                   wb;
    logic                  trap;

    // model images of data memory and registers
    logic [7:0]            mem_img [4*DMEM_WORDS];
    logic [XLEN-1:0]       reg_img [32];
    logic [31:0]           lfsr = 32'd15615;

    // expected write-back handed from driver to checker
    logic                  next_valid = 1'b0;
    wb_t                   next_wb;
    logic                  next_trap;
    string                 next_name;
    logic                  pend_valid = 1'b0;
    wb_t                   pend_wb;
    logic                  pend_trap;
    string                 pend_name;
    int                    cycles = 0;

    tb_clock_gen u_clk_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    mem_wb_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) uut (
        .clk_i      (clk),
        .rstn_i     (rstn),
        .ex_mem_i   (ex_mem),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_o       (wb),
        .trap_o     (trap)
    );

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[0]};
            // galois step for x^32 + x^22 + x^2 + x + 1
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] pick_rd();
        logic [REG_ADDR_W-1:0] rd;
        rd = REG_ADDR_W'(rand_bits(REG_ADDR_W));
        return (rd == '0) ? REG_ADDR_W'(1) : rd;
    endfunction

    // byte index of one lane within the wrapped word address
    function automatic int lane_idx(input logic [XLEN-1:0] addr, input int lane);
        return int'({addr[BYTE_W-1:2], 2'(lane)});
    endfunction

    function automatic logic [XLEN-1:0] load_ref(input mem_oper_t op,
                                                 input logic [XLEN-1:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = mem_img[lane_idx(addr, int'(addr[1:0]))];
        h = {mem_img[lane_idx(addr, 2 * int'(addr[1]) + 1)],
             mem_img[lane_idx(addr, 2 * int'(addr[1]))]};
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'h0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'h0, h};
            MEM_LW:  return {mem_img[lane_idx(addr, 3)], mem_img[lane_idx(addr, 2)],
                             mem_img[lane_idx(addr, 1)], mem_img[lane_idx(addr, 0)]};
            default: return '0;
        endcase
    endfunction

    task automatic store_ref(input mem_oper_t op, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] data);
        case (op)
            MEM_SB:
            begin
                mem_img[lane_idx(addr, int'(addr[1:0]))] = data[7:0];
            end
            MEM_SH:
            begin
                mem_img[lane_idx(addr, 2 * int'(addr[1]))]     = data[7:0];
                mem_img[lane_idx(addr, 2 * int'(addr[1]) + 1)] = data[15:8];
            end
            MEM_SW:
            begin
                for (int i = 0; i < 4; i++)
                begin
                    mem_img[lane_idx(addr, i)] = data[8*i +: 8];
                end
            end
            default:
            begin
            end
        endcase
    endtask

    function automatic ex_mem_t make_item(input mem_oper_t op, input logic [XLEN-1:0] addr,
                                          input logic [XLEN-1:0] data,
                                          input logic [REG_ADDR_W-1:0] rd, input logic trap_in);
        ex_mem_t it;
        it            = '0;
        it.alu_result = addr;
        it.oper2      = data;
        it.mem_oper   = op;
        it.trap       = trap_in;
        it.wb_use_mem = op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
        it.write_rd   = !(op inside {MEM_SB, MEM_SH, MEM_SW});
        it.rd_addr    = rd;
        return it;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected we=%0b rd=%0d data=%08h, actual we=%0b rd=%0d data=%08h",
                     name, exp.we, exp.addr, exp.data, act.we, act.addr, act.data);
            stop_on_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected %08h, actual %08h", name, exp, act);
            stop_on_failure();
        end
    endtask

    // drives one item and works out what write-back shows a cycle later
    task automatic drive_item(input ex_mem_t it, input string name);
        wb_t exp;
        exp.we   = it.write_rd && !it.trap && (it.rd_addr != '0);
        exp.addr = it.rd_addr;
        exp.data = it.wb_use_mem ? load_ref(it.mem_oper, it.alu_result) : it.alu_result;
        if (exp.we)
        begin
            reg_img[exp.addr] = exp.data;
        end
        store_ref(it.mem_oper, it.alu_result, it.oper2);
        ex_mem     = it;
        next_wb    = exp;
        next_trap  = it.trap;
        next_name  = name;
        next_valid = 1'b1;
    endtask

    task automatic issue(input ex_mem_t it, input string name);
        @(negedge clk);
        drive_item(it, name);
    endtask

    task automatic drain();
        repeat (2) issue('0, "idle");
    endtask

    // reads registers in pairs and samples each pair one cycle after its addresses
    task automatic check_regs(input string name);
        for (int r = 0; r <= 32; r += 2)
        begin
            @(negedge clk);
            if (r > 0)
            begin
                check_word($sformatf("%s x%0d", name, r - 2), reg_img[r - 2], rs1_data);
                check_word($sformatf("%s x%0d", name, r - 1), reg_img[r - 1], rs2_data);
            end
            rs1_addr = REG_ADDR_W'(r);
            rs2_addr = REG_ADDR_W'(r + 1);
            drive_item('0, "idle");
        end
    endtask

    // the item driven before this edge is checked on the next falling edge
    always @(posedge clk)
    begin
        pend_valid = next_valid;
        pend_wb    = next_wb;
        pend_trap  = next_trap;
        pend_name  = next_name;
    end

    always @(negedge clk)
    begin
        if (pend_valid)
        begin
            check_wb(pend_name, pend_wb, wb);
            check_word({pend_name, " trap"}, XLEN'(pend_trap), XLEN'(trap));
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout: no result after %0d cycles", cycles);
            stop_on_failure();
        end
    end

    initial
    begin
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] addr;
        mem_oper_t       op;
        ex_mem_t         it;
        ex_mem   = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        for (int i = 0; i < 32; i++)
        begin
            reg_img[i] = '0;
        end

        @(posedge rstn);
        @(negedge clk);
        check_word("reset we", '0, XLEN'(wb.we));
        check_word("reset trap", '0, XLEN'(trap));
        check_regs("reset");

        // plain ALU results read back two cycles after they are presented
        repeat (4)
        begin
            it = make_item(MEM_NOP, rand_bits(32), '0, pick_rd(), 1'b0);
            issue(it, "alu write-back");
            rs1_addr = it.rd_addr;
            drain();
            check_word($sformatf("alu read x%0d", it.rd_addr), reg_img[it.rd_addr], rs1_data);
        end
        check_regs("alu");

        // stores into each lane read back as a word
        repeat (4)
        begin
            base = rand_bits(30) << 2;
            issue(make_item(MEM_SW, base, rand_bits(32), pick_rd(), 1'b0), "store SW");
            issue(make_item(MEM_LW, base, '0, pick_rd(), 1'b0), "load after SW");
            for (int off = 0; off < 4; off++)
            begin
                issue(make_item(MEM_SB, base + off, rand_bits(32), pick_rd(), 1'b0),
                      $sformatf("store SB +%0d", off));
                issue(make_item(MEM_LW, base, '0, pick_rd(), 1'b0),
                      $sformatf("load after SB +%0d", off));
            end
            for (int off = 0; off < 4; off += 2)
            begin
                issue(make_item(MEM_SH, base + off, rand_bits(32), pick_rd(), 1'b0),
                      $sformatf("store SH +%0d", off));
                issue(make_item(MEM_LW, base, '0, pick_rd(), 1'b0),
                      $sformatf("load after SH +%0d", off));
            end
        end
        drain();
        check_regs("stores");

        // narrow loads with sign and zero extension
        repeat (4)
        begin
            base = rand_bits(30) << 2;
            issue(make_item(MEM_SW, base, rand_bits(32), pick_rd(), 1'b0), "load setup");
            for (int off = 0; off < 4; off++)
            begin
                issue(make_item(MEM_LB, base + off, '0, pick_rd(), 1'b0),
                      $sformatf("load LB +%0d", off));
                issue(make_item(MEM_LBU, base + off, '0, pick_rd(), 1'b0),
                      $sformatf("load LBU +%0d", off));
            end
            for (int off = 0; off < 4; off += 2)
            begin
                issue(make_item(MEM_LH, base + off, '0, pick_rd(), 1'b0),
                      $sformatf("load LH +%0d", off));
                issue(make_item(MEM_LHU, base + off, '0, pick_rd(), 1'b0),
                      $sformatf("load LHU +%0d", off));
            end
        end
        drain();
        check_regs("loads");

        // trapped items and x0 destinations
        issue(make_item(MEM_NOP, rand_bits(32), '0, pick_rd(), 1'b1), "trapped alu");
        issue(make_item(MEM_LW, base, '0, pick_rd(), 1'b1), "trapped load");
        issue(make_item(MEM_NOP, rand_bits(32), '0, '0, 1'b0), "alu to x0");
        issue(make_item(MEM_LW, base, '0, '0, 1'b0), "load to x0");
        drain();
        check_regs("trap and x0");

        // random traffic inside a 16-word window where upper address bits wrap
        for (int w = 0; w < 16; w++)
        begin
            issue(make_item(MEM_SW, 32'(w * 4), rand_bits(32), '0, 1'b0), "window fill");
        end
        for (int n = 0; n < N_RANDOM; n++)
        begin
            op      = mem_oper_t'(4'(rand_bits(4) % 9));
            addr    = (rand_bits(22) << 10) | rand_bits(6);
            it      = make_item(op, addr, rand_bits(32), pick_rd(), 1'b0);
            // trapped stores would still write memory
            it.trap = !(op inside {MEM_SB, MEM_SH, MEM_SW}) && (rand_bits(3) == '0);
            issue(it, $sformatf("random %0d", n));
        end
        drain();
        check_regs("random");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule : tb_mem_wb

/* build.f */
common/riscv_pkg.sv
mem_stage/data_mem.sv
mem_stage/mem_rw.sv
rtl/reg_file.sv
rtl/mem_wb_top.sv
tb/tb_clock_gen.sv
tb/tb_mem_wb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_mem_wb -f build.f -Mdir obj_dir
	./obj_dir/Vtb_mem_wb | tee $(LOG)
	grep -q "^Simulation completed successfully$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
